/* dv/fps_checker.sv */
// --------------------
// fps checker
// watches the control unit ports, counts pulses per job
// and compares them with the expected counts
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fps_checker (
	input  wire got_fp,
	input  wire _0_f,
	input  wire efp,
	input  wire mode,
	input  wire step,
	input  wire strob_fp,
	input  wire strob2_fp,
	input  wire sr_fp,
	input  wire read_fp,
	input  wire rlp_fp,
	input  wire lpa,
	input  wire lpb,
	input  wire clockm,
	input  wire clockta,
	input  wire ekc_fp,
	output int  val_errs,
	output int  proto_errs,
	output int  jobs
);

	string job_name = "none";
	logic [31:0] exp_cnt = '0;
	int n_val_err = 0;
	int n_proto_err = 0;
	int n_jobs = 0;
	int n_rd;
	int n_m;
	int n_ta;
	int n_wr;
	int n_strob;
	int n_step;
	logic in_job = 1'b0;
	logic stepped = 1'b0;
	logic started = 1'b0;
	logic ended = 1'b0;
	logic seen_efp = 1'b0;
	logic want_s2 = 1'b0;

	assign val_errs = n_val_err;
	assign proto_errs = n_proto_err;
	assign jobs = n_jobs;

	// expected counts packed as read, clockm, clockta, rlp
	task automatic expect_job(input string name, input logic [31:0] exp);
		job_name = name;
		exp_cnt = exp;
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("ERR %s %s: expected %0d, actual %0d", job_name, what, exp, act);
			n_val_err++;
		end
	endtask

	task automatic protocol_error(input string msg);
		$display("%s: %s at %0t", job_name, msg, $time);
		n_proto_err++;
	endtask

	// --------------------
	// sampling
	// --------------------

	always @(posedge got_fp) begin
		if (_0_f) begin
			in_job = 1'b0;
			started = 1'b0;
			ended = 1'b0;
			want_s2 = 1'b0;
		end else begin
			// follow-ups one cycle after job start and end
			if (started && !sr_fp)
				protocol_error("sr_fp did not rise after efp was accepted");
			if (ended && sr_fp)
				protocol_error("sr_fp still high after ekc_fp");
			started = 1'b0;
			ended = 1'b0;

			if (!seen_efp && sr_fp)
				protocol_error("sr_fp high before any efp");
			if (!sr_fp && (strob_fp || strob2_fp || read_fp || rlp_fp ||
				clockm || clockta || ekc_fp))
				protocol_error("control pulse while the unit is idle");

			// strobe pairing
			if (strob_fp && strob2_fp) begin
				protocol_error("strob_fp and strob2_fp in the same cycle");
			end else if (strob_fp) begin
				if (want_s2)
					protocol_error("second strob_fp without strob2_fp between");
				want_s2 = 1'b1;
			end else if (strob2_fp) begin
				if (!want_s2)
					protocol_error("strob2_fp without a strob_fp before it");
				want_s2 = 1'b0;
			end
			if (mode && strob_fp && !step)
				protocol_error("strob_fp in step mode without a step pulse");

			// efp only starts a job from idle
			if (efp && !sr_fp) begin
				seen_efp = 1'b1;
				in_job = 1'b1;
				started = 1'b1;
				stepped = mode;
				n_rd = 0;
				n_m = 0;
				n_ta = 0;
				n_wr = 0;
				n_strob = 0;
				n_step = 0;
			end

			if (in_job) begin
				// word index follows the pulse number
				if (read_fp) begin
					compare_count("lp on read word", n_rd, int'({lpb, lpa}));
					n_rd++;
				end
				if (rlp_fp) begin
					compare_count("lp on write word", n_wr, int'({lpb, lpa}));
					n_wr++;
				end
				if (clockm)
					n_m++;
				if (clockta)
					n_ta++;
				if (strob_fp)
					n_strob++;
				if (step)
					n_step++;
			end

			if (ekc_fp) begin
				if (!in_job) begin
					protocol_error("ekc_fp outside a job");
				end else begin
					compare_count("read_fp count", int'(exp_cnt[31:24]), n_rd);
					compare_count("clockm count", int'(exp_cnt[23:16]), n_m);
					compare_count("clockta count", int'(exp_cnt[15:8]), n_ta);
					compare_count("rlp_fp count", int'(exp_cnt[7:0]), n_wr);
					if (stepped)
						compare_count("strobes for steps", n_step, n_strob);
					in_job = 1'b0;
					ended = 1'b1;
					n_jobs++;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tb_fps.sv */
// --------------------
// fps testbench
// runs jobs of every opcode through the control unit,
// free running and in single-step mode
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_fps;

	localparam int WORDS = 3;
	localparam int MANT_BITS = 8;
	localparam int NW = fp_cfg_pkg::FP_NORM_W;
	localparam int CLK_HALF = 20;
	localparam int STEP_GAP = 3;
	localparam int N_JOBS = 10;
	// worst job: every state step at the long wait plus the step gap
	localparam int MAX_STEPS = 2 * WORDS + 1 + MANT_BITS + (2 ** NW - 1);
	localparam int STEP_CYC = fp_cfg_pkg::FP_DLY_LONG + 2 + STEP_GAP + 2;
	localparam int JOB_CYC = MAX_STEPS * STEP_CYC + 16;
	localparam int WDOG_CYC = N_JOBS * JOB_CYC + 20;

	logic got_fp;
	logic _0_f;
	logic efp;
	fp_ctl_pkg::fp_op_e op;
	logic [NW-1:0] norm_count;
	logic mode;
	logic step;
	logic strob_fp;
	logic strob2_fp;
	logic sr_fp;
	logic read_fp;
	logic rlp_fp;
	logic lpa;
	logic lpb;
	logic clockm;
	logic clockta;
	logic ekc_fp;
	int val_errs;
	int proto_errs;
	int jobs;
	integer seed;

	fps #(
		.WORDS(WORDS),
		.MANT_BITS(MANT_BITS)
	) u_fps (
		.got_fp(got_fp),
		._0_f(_0_f),
		.efp(efp),
		.op(op),
		.norm_count(norm_count),
		.mode(mode),
		.step(step),
		.strob_fp(strob_fp),
		.strob2_fp(strob2_fp),
		.sr_fp(sr_fp),
		.read_fp(read_fp),
		.rlp_fp(rlp_fp),
		.lpa(lpa),
		.lpb(lpb),
		.clockm(clockm),
		.clockta(clockta),
		.ekc_fp(ekc_fp)
	);

	fps_checker u_chk (
		.got_fp(got_fp),
		._0_f(_0_f),
		.efp(efp),
		.mode(mode),
		.step(step),
		.strob_fp(strob_fp),
		.strob2_fp(strob2_fp),
		.sr_fp(sr_fp),
		.read_fp(read_fp),
		.rlp_fp(rlp_fp),
		.lpa(lpa),
		.lpb(lpb),
		.clockm(clockm),
		.clockta(clockta),
		.ekc_fp(ekc_fp),
		.val_errs(val_errs),
		.proto_errs(proto_errs),
		.jobs(jobs)
	);

	// expected pulse counts of one job: read, clockm, clockta, rlp
	function automatic logic [31:0] fp_expect(input fp_ctl_pkg::fp_op_e fop,
		input logic [NW-1:0] nc);
		logic [7:0] n_rd;
		logic [7:0] n_m;
		case (fop)
			fp_ctl_pkg::OP_AD, fp_ctl_pkg::OP_SD: begin
				n_rd = 8'(WORDS);
				n_m = 8'd1;
			end
			fp_ctl_pkg::OP_MW, fp_ctl_pkg::OP_DW: begin
				n_rd = 8'(WORDS);
				n_m = 8'(MANT_BITS);
			end
			default: begin
				// normalize only, no operands and no arithmetic step
				n_rd = 8'd0;
				n_m = 8'd0;
			end
		endcase
		return {n_rd, n_m, 8'(nc), 8'(WORDS)};
	endfunction

	// --------------------
	// one job
	// --------------------

	task automatic run_job(input string name, input fp_ctl_pkg::fp_op_e jop,
		input logic [NW-1:0] jnorm, input logic stepped, input logic poke);
		logic job_end;
		u_chk.expect_job(name, fp_expect(jop, jnorm));
		@(negedge got_fp);
		op = jop;
		norm_count = jnorm;
		mode = stepped;
		efp = 1'b1;
		@(negedge got_fp);
		efp = 1'b0;
		if (poke) begin
			repeat (6) @(negedge got_fp);
			// start request while busy, with other operands
			efp = 1'b1;
			op = fp_ctl_pkg::OP_NRF;
			norm_count = ~jnorm;
			@(negedge got_fp);
			efp = 1'b0;
		end
		if (stepped) begin
			job_end = 1'b0;
			while (!job_end) begin
				repeat (STEP_GAP) @(negedge got_fp);
				step = 1'b1;
				@(negedge got_fp);
				step = 1'b0;
				// the pair closes with strob2, ekc follows the last one
				@(posedge got_fp);
				while (!strob2_fp) @(posedge got_fp);
				@(posedge got_fp);
				job_end = ekc_fp;
			end
		end else begin
			@(posedge got_fp);
			while (!ekc_fp) @(posedge got_fp);
		end
		@(negedge got_fp);
		mode = 1'b0;
		repeat (4) @(negedge got_fp);
	endtask

	initial begin
		got_fp = 1'b0;
		forever #(CLK_HALF) got_fp = ~got_fp;
	end

	// watchdog
	initial begin
		#(WDOG_CYC * 2 * CLK_HALF);
		$display("watchdog: run did not finish within %0d cycles", WDOG_CYC);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'ha36e_5ec9;
		_0_f = 1'b1;
		efp = 1'b0;
		op = fp_ctl_pkg::OP_AD;
		norm_count = '0;
		mode = 1'b0;
		step = 1'b0;
		repeat (3) @(posedge got_fp);
		@(negedge got_fp);
		_0_f = 1'b0;
		// quiet period, the unit must stay idle
		repeat (5) @(negedge got_fp);

		run_job("add", fp_ctl_pkg::OP_AD, NW'($random(seed)), 1'b0, 1'b0);
		run_job("sub", fp_ctl_pkg::OP_SD, NW'($random(seed)), 1'b0, 1'b0);
		run_job("mul", fp_ctl_pkg::OP_MW, NW'($random(seed)), 1'b0, 1'b0);
		run_job("div", fp_ctl_pkg::OP_DW, NW'($random(seed)), 1'b0, 1'b0);
		run_job("nrf", fp_ctl_pkg::OP_NRF, NW'($random(seed)), 1'b0, 1'b0);
		run_job("add_no_norm", fp_ctl_pkg::OP_AD, '0, 1'b0, 1'b0);
		run_job("nrf_no_norm", fp_ctl_pkg::OP_NRF, '0, 1'b0, 1'b0);
		run_job("mul_busy_efp", fp_ctl_pkg::OP_MW, NW'($random(seed)), 1'b0, 1'b1);
		run_job("sub_stepped", fp_ctl_pkg::OP_SD, NW'($random(seed)), 1'b1, 1'b0);
		run_job("nrf_stepped", fp_ctl_pkg::OP_NRF, NW'($random(seed)), 1'b1, 1'b0);

		repeat (3) @(negedge got_fp);
		if (jobs != N_JOBS)
			$display("checker saw %0d finished jobs, expected %0d", jobs, N_JOBS);
		$display("errors: %0d value, %0d protocol, jobs %0d of %0d",
			val_errs, proto_errs, jobs, N_JOBS);
		if (val_errs == 0 && proto_errs == 0 && jobs == N_JOBS) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
hdl/fp_ctl_pkg.sv
hdl/fp_cfg_pkg.sv
hdl/fp_strobgen.sv
hdl/fp_lp_counter.sv
hdl/fp_seq.sv
hdl/fp_decode.sv
hdl/fps.sv
dv/fps_checker.sv
dv/tb_fps.sv

/* hdl/fp_cfg_pkg.sv */
// --------------------
// fp config constants
// strobe timing and field widths
// --------------------

`default_nettype none

package fp_cfg_pkg;

	// idle cycles between strob1 and strob2
	localparam int FP_DLY_SHORT = 2;
	// slow states: multiply/divide step and result write
	localparam int FP_DLY_LONG = 5;
	// strobe wait counter width
	localparam int FP_DLY_W = $clog2(FP_DLY_LONG);

	// leading-zero count from the datapath
	localparam int FP_NORM_W = 4;
	// LP word counter, up to four words
	localparam int FP_LP_W = 2;

endpackage

`default_nettype wire

/* hdl/fp_ctl_pkg.sv */
// --------------------
// fp control types
// sequencer states and the opcode set of the coprocessor
// --------------------

`default_nettype none

package fp_ctl_pkg;

	// --------------------
	// sequencer states
	// --------------------

	// one state per phase of a job, S_END gives the end-of-job pulse
	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_ALIGN,
		S_ADD,
		S_MULDIV,
		S_NORM,
		S_WRITE,
		S_END
	} fp_state_e;

	// --------------------
	// opcodes
	// --------------------

	// add, subtract, multiply, divide, normalize only
	typedef enum logic [2:0] {
		OP_AD,
		OP_SD,
		OP_MW,
		OP_DW,
		OP_NRF
	} fp_op_e;

endpackage

`default_nettype wire

/* hdl/fp_decode.sv */
// --------------------
// fp control decode
// gates strob1 by state into the datapath control pulses
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fp_decode (
	input  fp_ctl_pkg::fp_state_e                 state,
	input  wire                                   strob1,
	input  wire                                   strob2,
	input  wire [fp_cfg_pkg::FP_LP_W-1:0]         lp,
	output logic                                  read_fp,
	output logic                                  rlp_fp,
	output logic                                  clockm,
	output logic                                  clockta,
	output logic                                  strob_fp,
	output logic                                  strob2_fp,
	output logic                                  lpa,
	output logic                                  lpb
);

	// --------------------
	// datapath pulses
	// --------------------

	// each pulse is strob1 in its own state, one cycle wide
	always_comb begin
		read_fp = 1'b0;
		rlp_fp = 1'b0;
		clockm = 1'b0;
		clockta = 1'b0;
		case (state)
			fp_ctl_pkg::S_READ: begin
				// operand word fetch
				read_fp = strob1;
			end
			fp_ctl_pkg::S_ADD, fp_ctl_pkg::S_MULDIV: begin
				// one arithmetic step
				clockm = strob1;
			end
			fp_ctl_pkg::S_NORM: begin
				// one mantissa shift
				clockta = strob1;
			end
			fp_ctl_pkg::S_WRITE: begin
				// result word store
				rlp_fp = strob1;
			end
			default: begin
				// align, idle and end give no datapath pulse
				read_fp = 1'b0;
			end
		endcase
	end

	// strobes to the CPU side
	assign strob_fp = strob1;
	assign strob2_fp = strob2;

	// LP word select bits
	assign lpa = lp[0];
	assign lpb = lp[1];

endmodule

`default_nettype wire

/* hdl/fp_lp_counter.sv */
// --------------------
// LP word counter
// selects the operand or result word, flags the last one
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fp_lp_counter #(
	parameter int WORDS = 3
) (
	input  wire                             got_fp,
	input  wire                             _0_f,
	input  wire                             lp_load,
	input  wire                             lp_step,
	output logic [fp_cfg_pkg::FP_LP_W-1:0] lp,
	output logic                            lp_last
);

	localparam int LW = fp_cfg_pkg::FP_LP_W;
	localparam logic [LW-1:0] LP_MAX = LW'(WORDS - 1);

	assign lp_last = (lp == LP_MAX);

	// wraps back to word 0 after the last word, so the
	// write pass starts where the read pass did
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			lp <= '0;
		end else if (lp_load) begin
			lp <= '0;
		end else if (lp_step) begin
			if (lp_last) begin
				lp <= '0;
			end else begin
				lp <= lp + 1'b1;
			end
		end
	end

	// word index stays inside the transfer
	a_lp_range: assert property (@(posedge got_fp) disable iff (_0_f)
		lp <= LP_MAX);

endmodule

`default_nettype wire

/* hdl/fp_seq.sv */
// --------------------
// fp sequencer
// state register and next-state logic, job start on efp,
// end of job on ekc_fp
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fp_seq #(
	parameter int WORDS = 3,
	parameter int MANT_BITS = 8
) (
	input  wire                                got_fp,
	input  wire                                _0_f,
	input  wire                                efp,
	input  fp_ctl_pkg::fp_op_e                 op,
	input  wire [fp_cfg_pkg::FP_NORM_W-1:0]    norm_count,
	input  wire                                strob1,
	input  wire                                strob2,
	input  wire                                lp_last,
	output fp_ctl_pkg::fp_state_e              state,
	output logic                               long_step,
	output logic                               lp_load,
	output logic                               lp_step,
	output logic                               sr_fp,
	output logic                               ekc_fp
);

	localparam int NW = fp_cfg_pkg::FP_NORM_W;
	localparam int MB_W = (MANT_BITS > 1) ? $clog2(MANT_BITS) : 1;
	// loop counter must hold both the step count and the shift count
	localparam int LOOP_W = (MB_W > NW) ? MB_W : NW;
	localparam logic [LOOP_W-1:0] MD_LAST = LOOP_W'(MANT_BITS - 1);

	fp_ctl_pkg::fp_state_e state_nx;
	fp_ctl_pkg::fp_op_e op_q;
	logic [NW-1:0] norm_q;
	logic [LOOP_W-1:0] loop_cnt;
	logic [LOOP_W-1:0] loop_nx;
	logic [LOOP_W-1:0] norm_in_m1;
	logic [LOOP_W-1:0] norm_q_m1;
	logic accept;
	logic md_op;

	// start only from idle, a second efp mid-job is dropped
	assign accept = efp && (state == fp_ctl_pkg::S_IDLE);

	assign md_op = (op_q == fp_ctl_pkg::OP_MW) || (op_q == fp_ctl_pkg::OP_DW);
	assign norm_in_m1 = LOOP_W'(norm_count) - 1'b1;
	assign norm_q_m1 = LOOP_W'(norm_q) - 1'b1;

	assign sr_fp = (state != fp_ctl_pkg::S_IDLE);
	assign ekc_fp = (state == fp_ctl_pkg::S_END);
	assign long_step = (state == fp_ctl_pkg::S_MULDIV) || (state == fp_ctl_pkg::S_WRITE);
	assign lp_load = accept;
	// LP moves on each word transfer
	assign lp_step = strob2 &&
		((state == fp_ctl_pkg::S_READ) || (state == fp_ctl_pkg::S_WRITE));

	// --------------------
	// next state
	// --------------------

	always_comb begin
		state_nx = state;
		loop_nx = loop_cnt;
		case (state)
			fp_ctl_pkg::S_IDLE: begin
				if (accept) begin
					// NRF has no operands to fetch, go straight to normalize
					if (op == fp_ctl_pkg::OP_NRF) begin
						state_nx = (norm_count == '0) ? fp_ctl_pkg::S_WRITE : fp_ctl_pkg::S_NORM;
						loop_nx = norm_in_m1;
					end else begin
						state_nx = fp_ctl_pkg::S_READ;
					end
				end
			end
			fp_ctl_pkg::S_READ: begin
				if (strob2 && lp_last) begin
					state_nx = fp_ctl_pkg::S_ALIGN;
				end
			end
			fp_ctl_pkg::S_ALIGN: begin
				if (strob2) begin
					state_nx = md_op ? fp_ctl_pkg::S_MULDIV : fp_ctl_pkg::S_ADD;
					loop_nx = MD_LAST;
				end
			end
			fp_ctl_pkg::S_ADD, fp_ctl_pkg::S_MULDIV: begin
				// add is a single step, mul/div loops until the count runs out
				if (strob2) begin
					if (state == fp_ctl_pkg::S_ADD || loop_cnt == '0) begin
						state_nx = (norm_q == '0) ? fp_ctl_pkg::S_WRITE : fp_ctl_pkg::S_NORM;
						loop_nx = norm_q_m1;
					end else begin
						loop_nx = loop_cnt - 1'b1;
					end
				end
			end
			fp_ctl_pkg::S_NORM: begin
				if (strob2) begin
					if (loop_cnt == '0) begin
						state_nx = fp_ctl_pkg::S_WRITE;
					end else begin
						loop_nx = loop_cnt - 1'b1;
					end
				end
			end
			fp_ctl_pkg::S_WRITE: begin
				if (strob2 && lp_last) begin
					state_nx = fp_ctl_pkg::S_END;
				end
			end
			default: begin
				// S_END lasts a single cycle
				state_nx = fp_ctl_pkg::S_IDLE;
			end
		endcase
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			state <= fp_ctl_pkg::S_IDLE;
			loop_cnt <= '0;
		end else begin
			state <= state_nx;
			loop_cnt <= loop_nx;
		end
	end

	// job operands, captured when the job starts
	always_ff @(posedge got_fp) begin
		if (accept) begin
			op_q <= op;
			norm_q <= norm_count;
		end
	end

	// --------------------
	// checks
	// --------------------

	// execute states agree with the latched opcode, NRF skips them all
	a_state_legal: assert property (@(posedge got_fp) disable iff (_0_f)
		(state != fp_ctl_pkg::S_MULDIV || md_op) &&
		(state != fp_ctl_pkg::S_ADD || op_q == fp_ctl_pkg::OP_AD ||
			op_q == fp_ctl_pkg::OP_SD) &&
		(op_q != fp_ctl_pkg::OP_NRF || !(state inside {fp_ctl_pkg::S_READ,
			fp_ctl_pkg::S_ALIGN, fp_ctl_pkg::S_ADD, fp_ctl_pkg::S_MULDIV})));

	// end of job is one cycle, and no strobe belongs to it
	a_ekc_single: assert property (@(posedge got_fp) disable iff (_0_f)
		ekc_fp |-> !strob1 ##1 !ekc_fp);

endmodule

`default_nettype wire

/* hdl/fp_strobgen.sv */
// --------------------
// fp strobe generator
// issues one strob1/strob2 pair per state step, with a
// per-state wait between them and optional single stepping
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fp_strobgen (
	input  wire                   got_fp,
	input  wire                   _0_f,
	input  fp_ctl_pkg::fp_state_e state,
	input  wire                   long_step,
	input  wire                   mode,
	input  wire                   step,
	output logic                  strob1,
	output logic                  strob2
);

	localparam int DW = fp_cfg_pkg::FP_DLY_W;
	// counter runs down to zero, so load one less than the wait
	localparam logic [DW-1:0] WAIT_SHORT = DW'(fp_cfg_pkg::FP_DLY_SHORT - 1);
	localparam logic [DW-1:0] WAIT_LONG = DW'(fp_cfg_pkg::FP_DLY_LONG - 1);
	// strob1 to strob2 distance in cycles
	localparam int S2_SHORT = fp_cfg_pkg::FP_DLY_SHORT + 1;
	localparam int S2_LONG = fp_cfg_pkg::FP_DLY_LONG + 1;

	// armed, counting the wait, giving strob2
	typedef enum logic [1:0] {
		PH_ARM,
		PH_WAIT,
		PH_S2
	} phase_e;

	phase_e phase;
	logic [DW-1:0] wait_cnt;
	logic run;
	logic go;

	// strobes only in states that do work
	assign run = (state != fp_ctl_pkg::S_IDLE) && (state != fp_ctl_pkg::S_END);

	// free running, or held until the operator presses step
	assign go = ~mode | step;

	// strob1 leaves the armed phase directly, so a new pair can
	// follow strob2 on the very next cycle
	assign strob1 = (phase == PH_ARM) & run & go;
	assign strob2 = (phase == PH_S2);

	// --------------------
	// phase machine
	// --------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			phase <= PH_ARM;
			wait_cnt <= '0;
		end else begin
			case (phase)
				PH_ARM: begin
					if (strob1) begin
						phase <= PH_WAIT;
						wait_cnt <= long_step ? WAIT_LONG : WAIT_SHORT;
					end
				end
				PH_WAIT: begin
					if (wait_cnt == '0) begin
						phase <= PH_S2;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				PH_S2: begin
					phase <= PH_ARM;
				end
				default: begin
					phase <= PH_ARM;
				end
			endcase
		end
	end

	// strob2 closes the pair after the wait chosen at strob1
	a_pair_short: assert property (@(posedge got_fp) disable iff (_0_f)
		strob1 && !long_step |-> ##S2_SHORT strob2);

	a_pair_long: assert property (@(posedge got_fp) disable iff (_0_f)
		strob1 && long_step |-> ##S2_LONG strob2);

endmodule

`default_nettype wire

/* hdl/fps.sv */
// --------------------
// F-PS control unit
// sequencer, strobe generator, LP counter and decode
// --------------------

`timescale 1ns/1ps
`default_nettype none

module fps #(
	parameter int WORDS = 3,
	parameter int MANT_BITS = 8
) (
	input  wire                             got_fp,
	input  wire                             _0_f,
	input  wire                             efp,
	input  fp_ctl_pkg::fp_op_e              op,
	input  wire [fp_cfg_pkg::FP_NORM_W-1:0] norm_count,
	input  wire                             mode,
	input  wire                             step,
	output logic                            strob_fp,
	output logic                            strob2_fp,
	output logic                            sr_fp,
	output logic                            read_fp,
	output logic                            rlp_fp,
	output logic                            lpa,
	output logic                            lpb,
	output logic                            clockm,
	output logic                            clockta,
	output logic                            ekc_fp
);

	fp_ctl_pkg::fp_state_e state;
	logic long_step;
	logic strob1;
	logic strob2;
	logic lp_load;
	logic lp_step;
	logic [fp_cfg_pkg::FP_LP_W-1:0] lp;
	logic lp_last;

	fp_seq #(
		.WORDS(WORDS),
		.MANT_BITS(MANT_BITS)
	) u_seq (
		.got_fp(got_fp),
		._0_f(_0_f),
		.efp(efp),
		.op(op),
		.norm_count(norm_count),
		.strob1(strob1),
		.strob2(strob2),
		.lp_last(lp_last),
		.state(state),
		.long_step(long_step),
		.lp_load(lp_load),
		.lp_step(lp_step),
		.sr_fp(sr_fp),
		.ekc_fp(ekc_fp)
	);

	fp_strobgen u_strobgen (
		.got_fp(got_fp),
		._0_f(_0_f),
		.state(state),
		.long_step(long_step),
		.mode(mode),
		.step(step),
		.strob1(strob1),
		.strob2(strob2)
	);

	fp_lp_counter #(
		.WORDS(WORDS)
	) u_lp (
		.got_fp(got_fp),
		._0_f(_0_f),
		.lp_load(lp_load),
		.lp_step(lp_step),
		.lp(lp),
		.lp_last(lp_last)
	);

	fp_decode u_decode (
		.state(state),
		.strob1(strob1),
		.strob2(strob2),
		.lp(lp),
		.read_fp(read_fp),
		.rlp_fp(rlp_fp),
		.clockm(clockm),
		.clockta(clockta),
		.strob_fp(strob_fp),
		.strob2_fp(strob2_fp),
		.lpa(lpa),
		.lpb(lpb)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the fps testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fps -f files.f -o sim_fps

./obj_dir/sim_fps > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

if ! grep -q "Test passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
